//--- hdl/ems_mapper.sv
/*
 * EMS page-map registers at 260h-263h
 * Also maps memory addresses in the EMS window onto a bank and its page
 */
`timescale 1ns/1ns
`include "xt_io_params.svh"

module ems_mapper import xt_io_pkg::*; (
    input  logic                     clock,
    input  logic                     reset,
    input  io_req_t                  req_i,
    input  logic                     req_valid_i,
    input  logic                     ems_enable_i,
    input  logic [1:0]               ems_segment_i,
    input  bus_addr_t                mem_addr_i,
    input  logic                     mem_access_i,
    output bus_data_t                rdata_o,
    output logic [`XT_EMS_BANKS-1:0] bank_hit_o,
    output ems_page_t                page_o
);

    ems_page_t                map_page [`XT_EMS_BANKS];
    logic [`XT_EMS_BANKS-1:0] map_ena;
    logic [3:0]               seg_nibble;
    logic                     reg_write;

    assign reg_write = req_valid_i & req_i.we & (req_i.target == TGT_EMS) & ems_enable_i;

    // FFh disables, below 80h maps a page, anything else is ignored
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            map_ena <= '0;
            for (int i = 0; i < `XT_EMS_BANKS; i++)
                map_page[i] <= '0;
        end else if (reg_write) begin
            if (req_i.wdata == `XT_EMS_DISABLE) begin
                map_ena[req_i.reg_idx] <= 1'b0;
            end else if (req_i.wdata < `XT_EMS_PAGE_LIMIT) begin
                map_ena[req_i.reg_idx]  <= 1'b1;
                map_page[req_i.reg_idx] <= req_i.wdata[6:0];
            end
        end
    end

    // Disabled bank or switched-off EMS reads like an empty port
    assign rdata_o = (ems_enable_i && map_ena[req_i.reg_idx]) ?
                     {1'b0, map_page[req_i.reg_idx]} : `XT_UNMAPPED_DATA;

    // Window base: A000h, C000h or D000h segment
    always_comb begin
        case (ems_segment_i)
            2'd0:    seg_nibble = 4'hA;
            2'd1:    seg_nibble = 4'hC;
            default: seg_nibble = 4'hD;
        endcase
    end

    // 16 KB banks, at most one can match a given address
    always_comb begin
        bank_hit_o = '0;
        page_o     = '0;
        for (int n = 0; n < `XT_EMS_BANKS; n++) begin
            if (mem_access_i && map_ena[n] &&
                mem_addr_i[19:14] == {seg_nibble, 2'(n)}) begin
                bank_hit_o[n] = 1'b1;
                page_o        = map_page[n];
            end
        end
    end

endmodule

//--- hdl/io_decode_stage.sv
/*
 * Stage 1 of the I/O hub
 * Accepts a Wishbone classic request, decodes the port and registers it
 */
`timescale 1ns/1ns
`include "xt_io_params.svh"

module io_decode_stage import xt_io_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  logic      wb_cyc_i,
    input  logic      wb_stb_i,
    input  logic      wb_we_i,
    input  bus_addr_t wb_adr_i,
    input  bus_data_t wb_dat_i,
    input  logic      io_space_i,
    input  logic      done_i,
    output io_req_t   req_o,
    output logic      req_valid_o
);

    logic       busy;
    logic       accept;
    io_target_e target;

    // One request in flight, held off until stage 2 reports done
    assign accept = wb_cyc_i & wb_stb_i & ~busy;

    // Memory cycles and unknown ports fall through to TGT_NONE
    always_comb begin
        target = TGT_NONE;
        if (io_space_i) begin
            if (wb_adr_i[15:2] == `XT_EMS_BASE >> 2)
                target = TGT_EMS;
            else if (wb_adr_i[15:0] == `XT_LPT_DATA)
                target = TGT_LPT_DATA;
            else if (wb_adr_i[15:0] == `XT_LPT_STATUS)
                target = TGT_LPT_STATUS;
        end
    end

    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            busy        <= 1'b0;
            req_valid_o <= 1'b0;
        end else begin
            req_valid_o <= accept;
            if (accept)
                busy <= 1'b1;
            else if (done_i)
                busy <= 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            req_o.addr    <= wb_adr_i;
            req_o.wdata   <= wb_dat_i;
            req_o.we      <= wb_we_i;
            req_o.target  <= target;
            req_o.reg_idx <= wb_adr_i[1:0];
        end
    end

endmodule

//--- hdl/lpt_port.sv
/*
 * Parallel port at 378h-379h
 * Data latch plus a status byte carrying the DSS full flag
 */
`timescale 1ns/1ns
`include "xt_io_params.svh"

module lpt_port import xt_io_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  io_req_t   req_i,
    input  logic      req_valid_i,
    input  logic      dss_full_i,
    output bus_data_t data_o,
    output bus_data_t status_o
);

    always_ff @(posedge clock, posedge reset) begin
        if (reset)
            data_o <= '0;
        else if (req_valid_i && req_i.we && req_i.target == TGT_LPT_DATA)
            data_o <= req_i.wdata;
    end

    // Only the DSS flag is implemented, other bits read 0
    always_comb begin
        status_o                   = '0;
        status_o[`XT_DSS_FULL_BIT] = dss_full_i;
    end

endmodule

//--- hdl/read_return_stage.sv
/*
 * Stage 2 of the I/O hub
 * Picks the read byte for the decoded target and acks the request
 */
`timescale 1ns/1ns
`include "xt_io_params.svh"

module read_return_stage import xt_io_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    input  io_req_t   req_i,
    input  logic      req_valid_i,
    input  bus_data_t ems_rdata_i,
    input  bus_data_t lpt_data_i,
    input  bus_data_t lpt_status_i,
    output bus_data_t wb_dat_o,
    output logic      wb_ack_o,
    output logic      done_o
);

    bus_data_t rdata;

    always_comb begin
        if (req_i.we) begin
            rdata = '0;
        end else begin
            case (req_i.target)
                TGT_EMS:        rdata = ems_rdata_i;
                TGT_LPT_DATA:   rdata = lpt_data_i;
                TGT_LPT_STATUS: rdata = lpt_status_i;
                default:        rdata = `XT_UNMAPPED_DATA;
            endcase
        end
    end

    // Ack and done are single-cycle pulses
    always_ff @(posedge clock, posedge reset) begin
        if (reset) begin
            wb_ack_o <= 1'b0;
            done_o   <= 1'b0;
        end else begin
            wb_ack_o <= req_valid_i;
            done_o   <= req_valid_i;
        end
    end

    always_ff @(posedge clock) begin
        if (req_valid_i)
            wb_dat_o <= rdata;
    end

endmodule

//--- hdl/xt_io_hub.sv
/*
 * XT chipset I/O hub
 * Wishbone slave with EMS page mapping and a parallel port, two-stage pipeline
 */
`timescale 1ns/1ns
`include "xt_io_params.svh"

module xt_io_hub import xt_io_pkg::*; (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     wb_cyc_i,
    input  logic                     wb_stb_i,
    input  logic                     wb_we_i,
    input  bus_addr_t                wb_adr_i,
    input  bus_data_t                wb_dat_i,
    output bus_data_t                wb_dat_o,
    output logic                     wb_ack_o,
    input  logic                     io_space_i,
    input  logic                     ems_enable_i,
    input  logic [1:0]               ems_segment_i,
    input  logic                     dss_full_i,
    output logic [`XT_EMS_BANKS-1:0] ems_bank_hit_o,
    output ems_page_t                ems_page_o,
    output bus_data_t                lpt_data_o
);

    io_req_t   req;
    logic      req_valid;
    logic      done;
    logic      mem_access;
    bus_data_t ems_rdata;
    bus_data_t lpt_status;

    // Bank lookup runs straight off the live memory cycle
    assign mem_access = wb_cyc_i & wb_stb_i & ~io_space_i;

    io_decode_stage u_decode (
        .clock       (clock),
        .reset       (reset),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .io_space_i  (io_space_i),
        .done_i      (done),
        .req_o       (req),
        .req_valid_o (req_valid)
    );

    ems_mapper u_ems (
        .clock         (clock),
        .reset         (reset),
        .req_i         (req),
        .req_valid_i   (req_valid),
        .ems_enable_i  (ems_enable_i),
        .ems_segment_i (ems_segment_i),
        .mem_addr_i    (wb_adr_i),
        .mem_access_i  (mem_access),
        .rdata_o       (ems_rdata),
        .bank_hit_o    (ems_bank_hit_o),
        .page_o        (ems_page_o)
    );

    lpt_port u_lpt (
        .clock       (clock),
        .reset       (reset),
        .req_i       (req),
        .req_valid_i (req_valid),
        .dss_full_i  (dss_full_i),
        .data_o      (lpt_data_o),
        .status_o    (lpt_status)
    );

    read_return_stage u_return (
        .clock        (clock),
        .reset        (reset),
        .req_i        (req),
        .req_valid_i  (req_valid),
        .ems_rdata_i  (ems_rdata),
        .lpt_data_i   (lpt_data_o),
        .lpt_status_i (lpt_status),
        .wb_dat_o     (wb_dat_o),
        .wb_ack_o     (wb_ack_o),
        .done_o       (done)
    );

endmodule

//--- hdl/xt_io_params.svh
/*
 * XT I/O hub constants
 * Port addresses, EMS bank limits and fixed read values
 */
`ifndef XT_IO_PARAMS_SVH
`define XT_IO_PARAMS_SVH

// I/O port map, low 16 bits of the bus address
`define XT_EMS_BASE         16'h0260
`define XT_LPT_DATA         16'h0378
`define XT_LPT_STATUS       16'h0379

// EMS page-map control
`define XT_EMS_BANKS        4
`define XT_EMS_DISABLE      8'hFF
`define XT_EMS_PAGE_LIMIT   8'h80

// Read side
`define XT_UNMAPPED_DATA    8'hFF
// Status bit that carries the DSS FIFO full flag
`define XT_DSS_FULL_BIT     6

`endif

//--- hdl/xt_io_pkg.sv
/*
 * XT I/O hub types
 * Bus widths, decoded target and the request carried between stages
 */
package xt_io_pkg;

    // 20-bit XT bus address, I/O ports use the low 16 bits
    typedef logic [19:0] bus_addr_t;

    // One data byte
    typedef logic [7:0] bus_data_t;

    // EMS page number, 128 pages of 16 KB
    typedef logic [6:0] ems_page_t;

    // Which register block a request goes to
    typedef enum logic [1:0] {
        TGT_NONE       = 2'd0,
        TGT_EMS        = 2'd1,
        TGT_LPT_DATA   = 2'd2,
        TGT_LPT_STATUS = 2'd3
    } io_target_e;

    // Request registered by stage 1
    typedef struct packed {
        bus_addr_t  addr;
        bus_data_t  wdata;
        logic       we;
        io_target_e target;
        logic [1:0] reg_idx;
    } io_req_t;

endpackage

//--- test/tb_bus_tasks.svh
/*
 * Wishbone master tasks and reference model for the XT I/O hub testbench
 * Included inside the testbench module
 */

// Reference copies of the DUT state and of the driven controls
ems_page_t  model_page [4];
logic [3:0] model_ena;
bus_data_t  model_lpt;
logic       model_enable;
logic       model_dss;
logic [1:0] model_seg;

function automatic logic is_ems_port(input logic [15:0] port);
    return port >= `XT_EMS_BASE && port < `XT_EMS_BASE + 4;
endfunction

// A000h, C000h, D000h, D000h
function automatic logic [3:0] window_nibble(input logic [1:0] seg);
    return (seg == 2'd0) ? 4'hA : (seg == 2'd1) ? 4'hC : 4'hD;
endfunction

function automatic void model_ems_write(input logic [1:0] idx, input bus_data_t data);
    if (!model_enable)
        return;
    if (data == `XT_EMS_DISABLE) begin
        model_ena[idx] = 1'b0;
    end else if (data < `XT_EMS_PAGE_LIMIT) begin
        model_ena[idx]  = 1'b1;
        model_page[idx] = data[6:0];
    end
endfunction

function automatic bus_data_t model_read(input logic [15:0] port);
    if (is_ems_port(port))
        return (model_enable && model_ena[port[1:0]]) ?
               {1'b0, model_page[port[1:0]]} : `XT_UNMAPPED_DATA;
    if (port == `XT_LPT_DATA)
        return model_lpt;
    if (port == `XT_LPT_STATUS)
        return bus_data_t'(model_dss) << `XT_DSS_FULL_BIT;
    return `XT_UNMAPPED_DATA;
endfunction

function automatic void model_lookup(input bus_addr_t addr);
    exp_hit  = '0;
    exp_page = '0;
    for (int n = 0; n < 4; n++) begin
        if (model_ena[n] && addr[19:16] == window_nibble(model_seg) &&
            addr[15:14] == n[1:0]) begin
            exp_hit[n] = 1'b1;
            exp_page   = model_page[n];
        end
    end
endfunction

// Disable, valid page or ignored value, one third each
function automatic bus_data_t pick_ems_value();
    case ($urandom % 3)
        0:       return `XT_EMS_DISABLE;
        1:       return bus_data_t'($urandom % 128);
        default: return bus_data_t'(8'h80 + $urandom % 127);
    endcase
endfunction

task automatic set_controls(input logic enable, input logic [1:0] seg, input logic dss);
    @(posedge clock);
    ems_enable_i  <= enable;
    ems_segment_i <= seg;
    dss_full_i    <= dss;
    model_enable = enable;
    model_seg    = seg;
    model_dss    = dss;
endtask

// One Wishbone classic cycle, strobe held until ack
task automatic bus_cycle(input logic io, input logic we, input bus_addr_t adr,
                         input bus_data_t wdata, input bus_data_t expected);
    int waited;
    exp_rdata = expected;
    if (io) begin
        exp_hit  = '0;
        exp_page = '0;
    end else begin
        model_lookup(adr);
    end
    @(posedge clock);
    wb_cyc_i   <= 1'b1;
    wb_stb_i   <= 1'b1;
    wb_we_i    <= we;
    wb_adr_i   <= adr;
    wb_dat_i   <= wdata;
    io_space_i <= io;
    waited = 0;
    do begin
        @(posedge clock);
        waited++;
    end while (!wb_ack_o && waited < ACK_TIMEOUT);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    if (!wb_ack_o) begin
        errors++;
        $display("No acknowledge from the DUT for address %05h", adr);
    end
endtask

task automatic io_write(input logic [15:0] port, input bus_data_t data);
    if (is_ems_port(port))
        model_ems_write(port[1:0], data);
    else if (port == `XT_LPT_DATA)
        model_lpt = data;
    bus_cycle(1'b1, 1'b1, {4'h0, port}, data, 8'h00);
endtask

task automatic io_read(input logic [15:0] port);
    bus_cycle(1'b1, 1'b0, {4'h0, port}, 8'h00, model_read(port));
endtask

// Memory cycles decode to no port and read FFh
task automatic mem_read(input bus_addr_t addr);
    bus_cycle(1'b0, 1'b0, addr, 8'h00, `XT_UNMAPPED_DATA);
endtask

//--- test/tb_xt_io_hub.sv
/*
 * Testbench for the XT I/O hub
 * Drives Wishbone cycles and checks the responses with assertions
 */
`timescale 1ns/1ns
`include "xt_io_params.svh"

module tb_xt_io_hub
    import xt_io_pkg::*;
();

    localparam int CLK_PERIOD      = 4;
    localparam int RESET_CYCLES    = 10;
    localparam int ACK_TIMEOUT     = 8;
    // Upper bound on bus cycles and control changes in the whole run
    localparam int TEST_OPS        = 180;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES * 2 + TEST_OPS * (ACK_TIMEOUT + 3);
    localparam logic [31:0] SEED   = 32'hfa0ff184;

    logic       clock = 1'b0;
    logic       reset;
    logic       wb_cyc_i;
    logic       wb_stb_i;
    logic       wb_we_i;
    bus_addr_t  wb_adr_i;
    bus_data_t  wb_dat_i;
    bus_data_t  wb_dat_o;
    logic       wb_ack_o;
    logic       io_space_i;
    logic       ems_enable_i;
    logic [1:0] ems_segment_i;
    logic       dss_full_i;
    logic [3:0] ems_bank_hit_o;
    ems_page_t  ems_page_o;
    bus_data_t  lpt_data_o;

    // Expected responses for the cycle in flight
    bus_data_t  exp_rdata;
    logic [3:0] exp_hit;
    ems_page_t  exp_page;
    int         errors = 0;

    xt_io_hub dut_i (.*);

    `include "tb_bus_tasks.svh"

    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic report_fail(input string msg);
        errors++;
        $display("Fail at time %0t: %s", $time, msg);
    endtask

    assert property (@(posedge clock) $fell(reset) |->
        !wb_ack_o && lpt_data_o == '0 && ems_bank_hit_o == '0 && ems_page_o == '0)
        else report_fail("outputs not cleared by reset");

    // Ack two edges after the request is first seen, for one cycle
    assert property (@(posedge clock) disable iff (reset)
        $rose(wb_cyc_i && wb_stb_i) |-> ##2 wb_ack_o ##1 !wb_ack_o)
        else report_fail("ack not a single pulse 2 cycles after the request");

    assert property (@(posedge clock) disable iff (reset)
        wb_ack_o |-> $past(wb_cyc_i && wb_stb_i, 2))
        else report_fail("ack without a request");

    assert property (@(posedge clock) disable iff (reset) wb_ack_o |-> wb_dat_o == exp_rdata)
        else report_fail($sformatf("read data %h, expected %h",
                                   $sampled(wb_dat_o), $sampled(exp_rdata)));

    assert property (@(posedge clock) disable iff (reset) wb_ack_o |-> lpt_data_o == model_lpt)
        else report_fail($sformatf("LPT data %h, expected %h",
                                   $sampled(lpt_data_o), $sampled(model_lpt)));

    assert property (@(posedge clock) disable iff (reset) wb_cyc_i && wb_stb_i |->
        ems_bank_hit_o == exp_hit && ems_page_o == exp_page)
        else report_fail($sformatf("bank hit %b page %h, expected %b page %h",
                                   $sampled(ems_bank_hit_o), $sampled(ems_page_o),
                                   $sampled(exp_hit), $sampled(exp_page)));

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Watchdog timeout, the run did not end within %0d cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        logic [15:0] port;
        bus_data_t   data;
        void'($urandom(SEED));
        reset         = 1'b1;
        wb_cyc_i      = 1'b0;
        wb_stb_i      = 1'b0;
        wb_we_i       = 1'b0;
        wb_adr_i      = '0;
        wb_dat_i      = '0;
        io_space_i    = 1'b0;
        ems_enable_i  = 1'b0;
        ems_segment_i = 2'd0;
        dss_full_i    = 1'b0;
        model_ena     = '0;
        model_lpt     = '0;
        model_enable  = 1'b0;
        model_dss     = 1'b0;
        model_seg     = 2'd0;
        for (int i = 0; i < 4; i++)
            model_page[i] = '0;
        repeat (RESET_CYCLES) @(posedge clock);
        reset <= 1'b0;

        // Page-map writes with a readback after each
        set_controls(1'b1, 2'd0, 1'b0);
        repeat (24) begin
            port = 16'(`XT_EMS_BASE + $urandom % 4);
            io_write(port, pick_ems_value());
            io_read(port);
        end

        // Registers hold while EMS is switched off
        set_controls(1'b0, 2'd0, 1'b0);
        repeat (8)
            io_write(16'(`XT_EMS_BASE + $urandom % 4), pick_ems_value());
        for (int i = 0; i < 4; i++)
            io_read(16'(`XT_EMS_BASE + i));
        set_controls(1'b1, 2'd0, 1'b0);
        for (int i = 0; i < 4; i++)
            io_read(16'(`XT_EMS_BASE + i));

        // Bank lookup in every window and again with bank 2 off
        for (int i = 0; i < 4; i++)
            io_write(16'(`XT_EMS_BASE + i), bus_data_t'($urandom % 128));
        for (int pass = 0; pass < 2; pass++) begin
            for (int seg = 0; seg < 4; seg++) begin
                set_controls(1'b1, 2'(seg), 1'b0);
                for (int bank = 0; bank < 4; bank++)
                    mem_read({window_nibble(2'(seg)), 2'(bank), 14'($urandom)});
                mem_read(bus_addr_t'($urandom % 32'h9_0000));
            end
            io_write(16'(`XT_EMS_BASE + 2), `XT_EMS_DISABLE);
        end

        // Memory cycles on port numbers stay unmapped
        mem_read({4'h1, `XT_EMS_BASE});
        mem_read({4'h1, `XT_LPT_DATA});

        // Parallel port data and status
        repeat (4) begin
            data = bus_data_t'($urandom);
            io_write(`XT_LPT_DATA, data);
            io_read(`XT_LPT_DATA);
        end
        set_controls(1'b1, 2'd0, 1'b1);
        io_read(`XT_LPT_STATUS);
        set_controls(1'b1, 2'd0, 1'b0);
        io_read(`XT_LPT_STATUS);

        // Unmapped ports
        repeat (16) begin
            do
                port = 16'($urandom);
            while (is_ems_port(port) || port == `XT_LPT_DATA || port == `XT_LPT_STATUS);
            io_read(port);
        end

        repeat (4) @(posedge clock);
        $display("Run complete with %0d errors", errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

//--- xt_io_hub.f
+incdir+hdl
+incdir+test
hdl/xt_io_pkg.sv
hdl/io_decode_stage.sv
hdl/ems_mapper.sv
hdl/lpt_port.sv
hdl/read_return_stage.sv
hdl/xt_io_hub.sv
test/tb_xt_io_hub.sv
